/* include/icache_defs.svh */
// instruction cache geometry, address field widths and replacement LFSR constants
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// geometry
`define ICACHE_WAYS       4
`define ICACHE_SETS       16
`define ICACHE_LINE_WORDS 4
`define ICACHE_WORD_W     32
`define ICACHE_ADDR_W     32

// derived widths
`define ICACHE_WAY_W  ($clog2(`ICACHE_WAYS))
`define ICACHE_IDX_W  ($clog2(`ICACHE_SETS))
`define ICACHE_OFF_W  ($clog2(`ICACHE_LINE_WORDS * `ICACHE_WORD_W / 8))
`define ICACHE_WSEL_W ($clog2(`ICACHE_LINE_WORDS))
`define ICACHE_TAG_W  (`ICACHE_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFF_W)
`define ICACHE_LINE_W (`ICACHE_LINE_WORDS * `ICACHE_WORD_W)

// replacement lfsr, galois form of x^8 + x^6 + x^5 + x^4 + 1
`define ICACHE_LFSR_W    8
`define ICACHE_LFSR_SEED 8'hA5
`define ICACHE_LFSR_TAPS 8'hB8

`endif

/* rtl/icache_pkg.sv */
// shared structs and enums of the instruction cache and its testbench
`include "icache_defs.svh"

package icache_pkg;

  // word-aligned fetch address
  typedef struct packed {
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [`ICACHE_WORD_W-1:0] data;
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_rsp_t;

  // line refill request, nc marks a fill that is not written into the arrays
  typedef struct packed {
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic [`ICACHE_WAY_W-1:0]  way;
    logic                      nc;
  } fill_req_t;

  typedef enum logic {IFILL, INVAL} rtrn_type_e;

  typedef struct packed {
    rtrn_type_e                rtype;
    logic [`ICACHE_LINE_W-1:0] data;
    // invalidation target
    logic [`ICACHE_IDX_W-1:0]  idx;
    logic                      all;
    logic                      vld;
    logic [`ICACHE_WAY_W-1:0]  way;
  } mem_rtrn_t;

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} ctrl_state_e;

  // array commands, reads and writes use separate set indices
  typedef struct packed {
    logic                     rd;
    logic                     wr;
    logic                     vld_we;
    logic                     all_ways;
    logic                     vld_wdata;
    logic [`ICACHE_IDX_W-1:0] rd_idx;
    logic [`ICACHE_IDX_W-1:0] idx;
  } array_cmd_t;

endpackage

/* rtl/icache_tag_array.sv */
// per-way tag and valid storage with synchronous read and hit compare
`include "icache_defs.svh"

module icache_tag_array (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  icache_pkg::array_cmd_t   cmd_i,
  input  logic [`ICACHE_TAG_W-1:0] tag_i,
  input  logic [`ICACHE_WAY_W-1:0] wr_way_i,
  input  icache_pkg::mem_rtrn_t    inv_i,
  output logic [`ICACHE_WAYS-1:0]  hit_o,
  output logic [`ICACHE_WAY_W-1:0] hit_way_o,
  output logic [`ICACHE_WAYS-1:0]  valid_o
);

  logic [`ICACHE_TAG_W-1:0] tag_mem  [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_WAYS-1:0]  vld_q    [`ICACHE_SETS];
  logic [`ICACHE_TAG_W-1:0] tag_rd_q [`ICACHE_WAYS];
  logic [`ICACHE_IDX_W-1:0] rd_idx_q;
  logic [`ICACHE_WAYS-1:0]  vld_mask;

  // ways touched by a valid write
  always_comb begin
    vld_mask = '0;
    if (cmd_i.all_ways) begin
      vld_mask = '1;
    end else if (cmd_i.wr) begin
      vld_mask[wr_way_i] = 1'b1;
    end else begin
      vld_mask[inv_i.way] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        vld_q[s] <= '0;
      end
      rd_idx_q <= '0;
    end else begin
      if (cmd_i.vld_we) begin
        vld_q[cmd_i.idx] <= (vld_q[cmd_i.idx] & ~vld_mask) |
                            (vld_mask & {`ICACHE_WAYS{cmd_i.vld_wdata}});
      end
      if (cmd_i.rd) begin
        rd_idx_q <= cmd_i.rd_idx;
      end
    end
  end

  // tags are read on the lookup edge, valid bits stay live for the read set
  always_ff @(posedge clk_i) begin
    if (cmd_i.wr) begin
      tag_mem[cmd_i.idx][wr_way_i] <= tag_i;
    end
    if (cmd_i.rd) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        tag_rd_q[w] <= tag_mem[cmd_i.rd_idx][w];
      end
    end
  end

  assign valid_o = vld_q[rd_idx_q];

  always_comb begin
    hit_way_o = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      hit_o[w] = valid_o[w] && (tag_rd_q[w] == tag_i);
      if (hit_o[w]) begin
        hit_way_o = w[`ICACHE_WAY_W-1:0];
      end
    end
  end

  // allocation in the controller never duplicates a tag within a set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_i.rd |=> $onehot0(hit_o))
    else $error("icache_tag_array: more than one way hits");

endmodule

/* rtl/icache_data_array.sv */
// per-way line storage with synchronous read and fetch word selection
`include "icache_defs.svh"

module icache_data_array (
  input  logic                      clk_i,
  input  icache_pkg::array_cmd_t    cmd_i,
  input  logic [`ICACHE_WAY_W-1:0]  wr_way_i,
  input  logic [`ICACHE_WSEL_W-1:0] offset_i,
  input  logic [`ICACHE_LINE_W-1:0] line_i,
  input  logic [`ICACHE_WAY_W-1:0]  hit_way_i,
  input  logic                      use_refill_i,
  output logic [`ICACHE_WORD_W-1:0] word_o
);

  logic [`ICACHE_LINE_W-1:0] line_mem  [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_LINE_W-1:0] line_rd_q [`ICACHE_WAYS];
  logic [`ICACHE_LINE_W-1:0] line_sel;

  // refill writes one way, lookup reads all ways of the set
  always_ff @(posedge clk_i) begin
    if (cmd_i.wr) begin
      line_mem[cmd_i.idx][wr_way_i] <= line_i;
    end
    if (cmd_i.rd) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        line_rd_q[w] <= line_mem[cmd_i.rd_idx][w];
      end
    end
  end

  // refill data bypasses the arrays on a miss
  assign line_sel = use_refill_i ? line_i : line_rd_q[hit_way_i];

  // word select by offset within the line
  assign word_o = line_sel[offset_i * `ICACHE_WORD_W +: `ICACHE_WORD_W];

endmodule

/* rtl/icache_victim_sel.sv */
// replacement way choice: lowest invalid way, else lfsr-driven random way
`include "icache_defs.svh"

module icache_victim_sel (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`ICACHE_WAYS-1:0]  valid_i,
  input  logic                     step_i,
  output logic [`ICACHE_WAY_W-1:0] victim_way_o
);

  logic [`ICACHE_LFSR_W-1:0] lfsr_q;
  logic [`ICACHE_WAY_W-1:0]  inv_way;
  logic                      all_valid;

  assign all_valid = &valid_i;

  // scan down so the lowest invalid way wins
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = w[`ICACHE_WAY_W-1:0];
      end
    end
  end

  // galois lfsr, advances only when a full set is refilled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `ICACHE_LFSR_SEED;
    end else if (step_i && all_valid) begin
      lfsr_q <= (lfsr_q >> 1) ^ ({`ICACHE_LFSR_W{lfsr_q[0]}} & `ICACHE_LFSR_TAPS);
    end
  end

  assign victim_way_o = all_valid ? lfsr_q[`ICACHE_WAY_W-1:0] : inv_way;

endmodule

/* rtl/icache_ctrl.sv */
// instruction cache controller sequencing flush, lookup, miss refill and invalidations
`include "icache_defs.svh"

module icache_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      en_i,
  input  logic                      flush_i,
  input  logic                      fetch_valid_i,
  input  icache_pkg::fetch_req_t    fetch_i,
  input  logic                      rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t     rtrn_i,
  input  logic [`ICACHE_WAYS-1:0]   hit_i,
  input  logic [`ICACHE_WAY_W-1:0]  victim_way_i,
  output icache_pkg::array_cmd_t    cmd_o,
  output logic                      use_refill_o,
  output logic                      rsp_valid_o,
  output logic [`ICACHE_ADDR_W-1:0] rsp_addr_o,
  output logic                      fill_valid_o,
  output icache_pkg::fill_req_t     fill_o,
  output logic                      busy_o,
  output logic                      miss_o
);

  icache_pkg::ctrl_state_e   state_q, state_d;
  logic [`ICACHE_IDX_W-1:0]  flush_cnt_q;
  logic                      flush_q, flush_d;
  logic                      cache_en_q, cache_en_d;
  // invalidation seen in the lookup strobe cycle
  logic                      inv_q;
  logic                      nc_q, nc_d;
  logic [`ICACHE_WAY_W-1:0]  way_q, way_d;
  logic [`ICACHE_ADDR_W-1:0] addr_q;
  logic                      inv_now, fill_now, fetch_take, hit_ok;

  assign inv_now    = rtrn_valid_i && (rtrn_i.rtype == icache_pkg::INVAL);
  assign fill_now   = rtrn_valid_i && (rtrn_i.rtype == icache_pkg::IFILL);
  assign fetch_take = (state_q == icache_pkg::IDLE) && fetch_valid_i;
  // an invalidation in either lookup cycle turns the hit into a miss
  assign hit_ok     = cache_en_q && (|hit_i) && !inv_q && !inv_now;

  assign busy_o       = (state_q != icache_pkg::IDLE);
  assign use_refill_o = (state_q == icache_pkg::MISS);
  assign rsp_addr_o   = addr_q;

  // line-aligned request whose way and nc follow the lookup result
  assign fill_o.addr = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFF_W], {`ICACHE_OFF_W{1'b0}}};
  assign fill_o.way  = way_d;
  assign fill_o.nc   = nc_d;

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    flush_d      = flush_q | flush_i;
    // disabling takes effect at once and enabling only through a flush
    cache_en_d   = cache_en_q & en_i;
    nc_d         = nc_q;
    way_d        = way_q;
    rsp_valid_o  = 1'b0;
    fill_valid_o = 1'b0;
    miss_o       = 1'b0;
    case (state_q)
      icache_pkg::FLUSH: begin
        if (&flush_cnt_q) begin
          state_d    = icache_pkg::IDLE;
          cache_en_d = en_i;
        end
      end
      icache_pkg::IDLE: begin
        // a fetch goes first and a pending flush waits for the next idle cycle
        if (fetch_valid_i) begin
          state_d = icache_pkg::READ;
        end else if (flush_d || (en_i && !cache_en_q)) begin
          state_d = icache_pkg::FLUSH;
          flush_d = 1'b0;
        end
      end
      icache_pkg::READ: begin
        if (hit_ok) begin
          rsp_valid_o = 1'b1;
          state_d     = icache_pkg::IDLE;
        end else begin
          // a line still present after a forced miss is refetched without allocating
          fill_valid_o = 1'b1;
          nc_d         = !cache_en_q || (|hit_i);
          miss_o       = !nc_d;
          way_d        = victim_way_i;
          state_d      = icache_pkg::MISS;
        end
      end
      icache_pkg::MISS: begin
        if (fill_now) begin
          rsp_valid_o = 1'b1;
          state_d     = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // array commands by priority of flush over invalidation over refill write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd_o        = '0;
    cmd_o.rd     = fetch_take && cache_en_q;
    cmd_o.rd_idx = fetch_i.addr[`ICACHE_IDX_W+`ICACHE_OFF_W-1:`ICACHE_OFF_W];
    cmd_o.idx    = addr_q[`ICACHE_IDX_W+`ICACHE_OFF_W-1:`ICACHE_OFF_W];
    if (state_q == icache_pkg::FLUSH) begin
      cmd_o.vld_we   = 1'b1;
      cmd_o.all_ways = 1'b1;
      cmd_o.idx      = flush_cnt_q;
    end else if (inv_now && (rtrn_i.all || rtrn_i.vld)) begin
      cmd_o.vld_we   = 1'b1;
      cmd_o.all_ways = rtrn_i.all;
      cmd_o.idx      = rtrn_i.idx;
    end else if ((state_q == icache_pkg::MISS) && fill_now && !nc_q && cache_en_q) begin
      cmd_o.wr        = 1'b1;
      cmd_o.vld_we    = 1'b1;
      cmd_o.vld_wdata = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::FLUSH;
      flush_cnt_q <= '0;
      flush_q     <= 1'b0;
      cache_en_q  <= 1'b0;
      inv_q       <= 1'b0;
      nc_q        <= 1'b0;
    end else begin
      state_q     <= state_d;
      // wraps to zero as the walk ends
      if (state_q == icache_pkg::FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
      flush_q     <= flush_d;
      cache_en_q  <= cache_en_d;
      inv_q       <= inv_now;
      nc_q        <= nc_d;
    end
  end

  // fetch address and victim way
  always_ff @(posedge clk_i) begin
    if (fetch_take) begin
      addr_q <= fetch_i.addr;
    end
    way_q <= way_d;
  end

  // outside a flush walk the set counter rests at zero
  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != icache_pkg::FLUSH) |-> (flush_cnt_q == '0))
    else $error("icache_ctrl: flush counter out of step with the state");

  // fill returns come only while a miss waits
  a_fill_in_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_now |-> (state_q == icache_pkg::MISS))
    else $error("icache_ctrl: fill return outside of a miss");

  a_no_fetch_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i |-> !busy_o)
    else $error("icache_ctrl: fetch strobe while busy");

endmodule

/* rtl/icache_top.sv */
// set-associative instruction cache top level joining controller and datapath
`include "icache_defs.svh"

module icache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic                   flush_i,
  input  logic                   fetch_valid_i,
  input  icache_pkg::fetch_req_t fetch_i,
  input  logic                   rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t  rtrn_i,
  output logic                   rsp_valid_o,
  output icache_pkg::fetch_rsp_t rsp_o,
  output logic                   fill_valid_o,
  output icache_pkg::fill_req_t  fill_o,
  output logic                   busy_o,
  output logic                   miss_o
);

  icache_pkg::array_cmd_t    cmd;
  logic [`ICACHE_WAYS-1:0]   hit_vec;
  logic [`ICACHE_WAYS-1:0]   valid_vec;
  logic [`ICACHE_WAY_W-1:0]  hit_way;
  logic [`ICACHE_WAY_W-1:0]  victim_way;
  logic                      use_refill;
  logic [`ICACHE_ADDR_W-1:0] rsp_addr;
  logic [`ICACHE_WORD_W-1:0] word;

  assign rsp_o.data = word;
  assign rsp_o.addr = rsp_addr;

  icache_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_i       (fetch_i),
    .rtrn_valid_i  (rtrn_valid_i),
    .rtrn_i        (rtrn_i),
    .hit_i         (hit_vec),
    .victim_way_i  (victim_way),
    .cmd_o         (cmd),
    .use_refill_o  (use_refill),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_addr_o    (rsp_addr),
    .fill_valid_o  (fill_valid_o),
    .fill_o        (fill_o),
    .busy_o        (busy_o),
    .miss_o        (miss_o)
  );

  // latched fetch address supplies tag and word offset, fill way is the write way
  icache_tag_array i_tag_array (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_i     (cmd),
    .tag_i     (rsp_addr[`ICACHE_ADDR_W-1:`ICACHE_ADDR_W-`ICACHE_TAG_W]),
    .wr_way_i  (fill_o.way),
    .inv_i     (rtrn_i),
    .hit_o     (hit_vec),
    .hit_way_o (hit_way),
    .valid_o   (valid_vec)
  );

  icache_data_array i_data_array (
    .clk_i        (clk_i),
    .cmd_i        (cmd),
    .wr_way_i     (fill_o.way),
    .offset_i     (rsp_addr[`ICACHE_OFF_W-1:`ICACHE_OFF_W-`ICACHE_WSEL_W]),
    .line_i       (rtrn_i.data),
    .hit_way_i    (hit_way),
    .use_refill_i (use_refill),
    .word_o       (word)
  );

  icache_victim_sel i_victim_sel (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_i      (valid_vec),
    .step_i       (cmd.wr),
    .victim_way_o (victim_way)
  );

endmodule

/* testbench/icache_tb.sv */
// testbench for the instruction cache: random fetches against a reference cache model
`include "icache_defs.svh"

module icache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_FETCH     = 400;
  localparam int IDLE_TIMEOUT  = 50;
  localparam int FLUSH_TIMEOUT = 4 * `ICACHE_SETS;

  logic                   clk_i = 1'b0;
  logic                   rst_ni, en_i, flush_i, fetch_valid_i, rtrn_valid_i;
  icache_pkg::fetch_req_t fetch_i;
  icache_pkg::mem_rtrn_t  rtrn_i;
  logic                   rsp_valid_o, fill_valid_o, busy_o, miss_o;
  icache_pkg::fetch_rsp_t rsp_o;
  icache_pkg::fill_req_t  fill_o;

  // reference model: valid bits and tags per set and way
  bit                       mvalid [`ICACHE_SETS][`ICACHE_WAYS];
  logic [`ICACHE_TAG_W-1:0] mtag   [`ICACHE_SETS][`ICACHE_WAYS];
  bit                       en_model;
  int                       next_tid;
  int                       n_chk [1:6];
  int                       n_err [1:6];

  icache_top uut (.*);

  always #10 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // model helpers
  //////////////////////////////////////////////////////////////////////

  // memory contents, every bit of the word address feeds the pattern
  function automatic logic [31:0] word_pat(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h9E37_79B9;
  endfunction

  function automatic int set_of(input logic [31:0] a);
    return int'(a[`ICACHE_IDX_W+`ICACHE_OFF_W-1:`ICACHE_OFF_W]);
  endfunction

  function automatic logic [`ICACHE_TAG_W-1:0] tag_of(input logic [31:0] a);
    return a[`ICACHE_ADDR_W-1:`ICACHE_ADDR_W-`ICACHE_TAG_W];
  endfunction

  function automatic logic [31:0] line_of(input logic [31:0] a);
    return {a[`ICACHE_ADDR_W-1:`ICACHE_OFF_W], {`ICACHE_OFF_W{1'b0}}};
  endfunction

  function automatic bit model_hit(input logic [31:0] a);
    int w;
    bit hit;
    hit = 1'b0;
    for (w = 0; w < `ICACHE_WAYS; w++) begin
      if (mvalid[set_of(a)][w] && (mtag[set_of(a)][w] == tag_of(a))) hit = 1'b1;
    end
    return hit;
  endfunction

  // lowest invalid way of a set, -1 when the set is full
  function automatic int first_invalid(input int s);
    int w;
    int way;
    way = -1;
    for (w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!mvalid[s][w]) way = w;
    end
    return way;
  endfunction

  // small pool, six tags over four sets forces hits and evictions
  function automatic logic [31:0] pick_addr();
    int tag;
    int set;
    int off;
    tag = $urandom_range(0, 5);
    set = $urandom_range(0, 3);
    off = $urandom_range(0, 3);
    return 32'h4000_0000 | (tag << (`ICACHE_IDX_W + `ICACHE_OFF_W)) |
           (set << `ICACHE_OFF_W) | (off << 2);
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "flush length and cold miss";
      2: return "response data";
      3: return "hit latency";
      4: return "miss after invalidation";
      5: return "disabled mode";
      default: return "victim choice";
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic check_bit(input int t, input string name, input logic got, input logic exp);
    n_chk[t]++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s = %b, expected %b", $time, name, got, exp);
      n_err[t]++;
    end
  endtask

  task automatic check_word(input int t, input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    n_chk[t]++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
      n_err[t]++;
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  // returns at a falling edge with the controller idle
  task automatic wait_idle();
    int  n;
    bit  idle;
    idle = 1'b0;
    for (n = 0; n < IDLE_TIMEOUT && !idle; n++) begin
      @(negedge clk_i);
      idle = !busy_o;
    end
    if (!idle) abort_run("busy_o to fall");
  endtask

  // counts busy cycles of a flush walk, then empties the model
  task automatic measure_flush();
    int n;
    int cnt;
    bit done;
    cnt  = 0;
    done = 1'b0;
    for (n = 0; n < FLUSH_TIMEOUT && !done; n++) begin
      @(negedge clk_i);
      if (busy_o) cnt++;
      else done = 1'b1;
    end
    if (!done) abort_run("the flush walk to end");
    check_word(1, "busy_o cycles", cnt, `ICACHE_SETS);
    for (n = 0; n < `ICACHE_SETS * `ICACHE_WAYS; n++) begin
      mvalid[n / `ICACHE_WAYS][n % `ICACHE_WAYS] = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // memory side, answers the pending fill after 1 to 5 cycles
  task automatic serve_fill(input logic [31:0] addr);
    icache_pkg::mem_rtrn_t rtn;
    logic [31:0]           line;
    int                    way;
    int                    w;
    int                    delay;
    bit                    nc;
    line = fill_o.addr;
    way  = int'(fill_o.way);
    nc   = fill_o.nc;
    rtn       = '0;
    rtn.rtype = icache_pkg::IFILL;
    for (w = 0; w < `ICACHE_LINE_WORDS; w++) begin
      rtn.data[w*`ICACHE_WORD_W +: `ICACHE_WORD_W] = word_pat(line + 4 * w);
    end
    delay = $urandom_range(1, 5);
    repeat (delay) @(posedge clk_i);
    rtrn_valid_i <= 1'b1;
    rtrn_i       <= rtn;
    // response rises in the cycle of the fill return
    @(negedge clk_i);
    check_bit(2, "rsp_valid_o", rsp_valid_o, 1'b1);
    check_word(2, "rsp_o.data", rsp_o.data, word_pat(addr));
    @(posedge clk_i);
    rtrn_valid_i <= 1'b0;
    if (!nc) begin
      mvalid[set_of(addr)][way] = 1'b1;
      mtag[set_of(addr)][way]   = tag_of(addr);
    end
  endtask

  // one fetch, tid names the test charged for a missing fill
  task automatic do_fetch(input logic [31:0] addr, input int tid);
    icache_pkg::fetch_req_t req;
    bit                     exp_hit;
    int                     exp_way;
    req.addr = addr;
    exp_hit  = en_model && model_hit(addr);
    exp_way  = first_invalid(set_of(addr));
    if (!en_model) tid = 5;
    @(posedge clk_i);
    fetch_valid_i <= 1'b1;
    fetch_i       <= req;
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    @(negedge clk_i);
    if (exp_hit) begin
      check_bit(3, "rsp_valid_o", rsp_valid_o, 1'b1);
      check_bit(3, "fill_valid_o", fill_valid_o, 1'b0);
      check_word(2, "rsp_o.data", rsp_o.data, word_pat(addr));
      check_word(2, "rsp_o.addr", rsp_o.addr, addr);
    end else begin
      check_bit(tid, "fill_valid_o", fill_valid_o, 1'b1);
      check_bit(tid, "miss_o", miss_o, en_model);
      check_bit(tid, "fill_o.nc", fill_o.nc, !en_model);
      check_word(tid, "fill_o.addr", fill_o.addr, line_of(addr));
      if (en_model && exp_way >= 0) check_word(6, "fill_o.way", 32'(fill_o.way), exp_way);
    end
    // a fill is served even when unexpected, so the controller never stalls
    if (fill_valid_o) serve_fill(addr);
  endtask

  // invalidates one way or a whole set, then probes a line that was held
  task automatic send_inval();
    icache_pkg::mem_rtrn_t rtn;
    logic [31:0]           probe;
    int                    set;
    int                    way;
    int                    off;
    int                    pw;
    int                    w;
    bit                    all;
    set = $urandom_range(0, 3);
    way = $urandom_range(0, `ICACHE_WAYS - 1);
    off = $urandom_range(0, `ICACHE_LINE_WORDS - 1);
    all = 1'($urandom_range(0, 1));
    pw  = all ? -1 : (mvalid[set][way] ? way : -1);
    for (w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (all && mvalid[set][w]) pw = w;
    end
    if (pw >= 0) begin
      probe = {mtag[set][pw], set[`ICACHE_IDX_W-1:0], off[`ICACHE_WSEL_W-1:0],
               {(`ICACHE_OFF_W - `ICACHE_WSEL_W){1'b0}}};
    end
    rtn       = '0;
    rtn.rtype = icache_pkg::INVAL;
    rtn.idx   = set[`ICACHE_IDX_W-1:0];
    rtn.all   = all;
    rtn.vld   = 1'b1;
    rtn.way   = way[`ICACHE_WAY_W-1:0];
    @(posedge clk_i);
    rtrn_valid_i <= 1'b1;
    rtrn_i       <= rtn;
    @(posedge clk_i);
    rtrn_valid_i <= 1'b0;
    for (w = 0; w < `ICACHE_WAYS; w++) begin
      if (all || (w == way)) mvalid[set][w] = 1'b0;
    end
    if (pw >= 0) begin
      wait_idle();
      do_fetch(probe, 4);
    end
  endtask

  task automatic do_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    measure_flush();
  endtask

  // dropping en_i takes effect at once, raising it starts a flush walk
  task automatic toggle_en();
    @(posedge clk_i);
    en_i <= !en_model;
    if (en_model) begin
      en_model = 1'b0;
    end else begin
      @(posedge clk_i);
      measure_flush();
      en_model = 1'b1;
      next_tid = 5;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int i;
    int r;
    int t;
    int tot_chk;
    int tot_err;
    void'($urandom(42));
    rst_ni        = 1'b0;
    en_i          = 1'b1;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_i       = '0;
    rtrn_valid_i  = 1'b0;
    rtrn_i        = '0;
    en_model      = 1'b1;
    next_tid      = 1;
    repeat (9) @(posedge clk_i);
    @(negedge clk_i);
    check_bit(1, "rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit(1, "fill_valid_o", fill_valid_o, 1'b0);
    check_bit(1, "miss_o", miss_o, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    measure_flush();

    for (i = 0; i < NUM_FETCH; i++) begin
      wait_idle();
      r = $urandom_range(0, 99);
      if (r < 3) begin
        do_flush();
        wait_idle();
      end else if (r < 9) begin
        send_inval();
        wait_idle();
      end else if (r < 12) begin
        toggle_en();
        wait_idle();
      end
      do_fetch(pick_addr(), next_tid);
      next_tid = 1;
    end

    tot_chk = 0;
    tot_err = 0;
    for (t = 1; t <= 6; t++) begin
      $display("test %0d %s: %0d checks, %0d errors", t, test_name(t), n_chk[t], n_err[t]);
      tot_chk += n_chk[t];
      tot_err += n_err[t];
    end
    $display("%0d fetches, %0d checks, %0d errors", NUM_FETCH, tot_chk, tot_err);
    if (tot_err == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* icache_lite.f */
+incdir+include
rtl/icache_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_victim_sel.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
testbench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the instruction cache testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module icache_tb -f icache_lite.f -o icache_sim

./obj_dir/icache_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run finished, no failure in sim.log"
